/* hdl/axis_pkg.sv */
//********************************************************************
// AXI-Stream side widths and types; tkeep is assumed contiguous from
// byte 0, and tdata carries byte 0 in its low bits
//********************************************************************
`default_nettype none

package axis_pkg;

    // Bytes per AXI-S beat
    localparam int DATA_BYTE_WID = 8;

    // Little-endian beat data, byte 0 in bits [7:0]
    typedef logic [DATA_BYTE_WID-1:0][7:0] tdata_t;

    // One enable bit per byte
    typedef logic [DATA_BYTE_WID-1:0] tkeep_t;

endpackage : axis_pkg

`default_nettype wire

/* hdl/packet_pkg.sv */
//********************************************************************
// Packet side widths and types; data is in network byte order and
// lengths above MAX_PKT_BYTES are reported saturated
//********************************************************************
`default_nettype none

package packet_pkg;

    // Same beat width as the AXI-S side
    localparam int PKT_BYTE_WID = axis_pkg::DATA_BYTE_WID;

    // Empty-byte count on the eop beat
    localparam int MTY_WID = $clog2(PKT_BYTE_WID);

    localparam int META_WID = 8;

    // Longest packet the length counter reports exactly
    localparam int MAX_PKT_BYTES = 2048;
    localparam int LEN_WID = 12;

    // Entries in the output skid buffer
    localparam int SKID_DEPTH = 2;

    // Byte 0 first, i.e. in the top bits
    typedef logic [0:PKT_BYTE_WID-1][7:0] data_t;
    typedef logic [MTY_WID-1:0] mty_t;
    // Flow tag
    typedef logic [META_WID-1:0] meta_t;
    typedef logic [LEN_WID-1:0] len_t;

    // One packet beat as it sits in the skid buffer
    typedef struct packed {
        data_t data;
        logic  eop;
        mty_t  mty;
        logic  err;
        meta_t meta;
    } pkt_beat_t;

endpackage : packet_pkg

`default_nettype wire

/* hdl/axi4s_to_packet_adapter.sv */
//********************************************************************
// One register stage; tready is looped back in from the skid buffer
// and qualifies acceptance. Sparse tkeep gives an undefined mty
//********************************************************************
`timescale 1ns/100ps
`default_nettype none

module axi4s_to_packet_adapter
    import axis_pkg::*;
    import packet_pkg::*;
#(
    parameter type meta_t = bit
) (
    input  wire logic   __packet_if,
    input  wire logic   rst_n,
    // AXI-S slave side
    input  wire logic   tvalid,
    input  wire logic   tready,
    input  wire tdata_t tdata,
    input  wire tkeep_t tkeep,
    input  wire logic   tlast,
    input  wire logic   err,
    input  wire meta_t  meta,
    // Registered packet beat
    output logic        stage_valid,
    output data_t       stage_data,
    output logic        stage_eop,
    output mty_t        stage_mty,
    output logic        stage_err,
    output meta_t       stage_meta
);

    logic accept;

    // Number of cleared enables, valid for contiguous tkeep only
    function automatic mty_t tkeep_to_mty(input tkeep_t keep);
        mty_t n;
        n = '0;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            if (!keep[i]) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign accept = tvalid && tready;

    always_ff @(posedge __packet_if or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= accept;
        end
    end

    // Payload only loads on a transfer
    always_ff @(posedge __packet_if) begin
        if (accept) begin
            stage_data <= {<<8{tdata}};
            stage_eop  <= tlast;
            stage_mty  <= tlast ? tkeep_to_mty(tkeep) : '0;
            stage_err  <= err;
            stage_meta <= meta;
        end
    end

    // Only the last beat of a packet may be partial
    a_full_keep: assert property (
        @(posedge __packet_if) disable iff (!rst_n)
        (accept && !tlast) |-> (tkeep == '1)
    ) else $error("partial tkeep on a non-tlast beat");

endmodule : axi4s_to_packet_adapter

`default_nettype wire

/* hdl/packet_skid_buffer.sv */
//********************************************************************
// in_rdy counts the upstream in-flight beat, so a write never finds
// the buffer full; oflow is sticky until reset
//********************************************************************
`timescale 1ns/100ps
`default_nettype none

module packet_skid_buffer
    import packet_pkg::*;
#(
    parameter type payload_t = pkt_beat_t,
    parameter int  DEPTH     = SKID_DEPTH
) (
    input  wire logic     __packet_if,
    input  wire logic     rst_n,
    // Write side, no back-pressure
    input  wire logic     wr_valid,
    input  wire payload_t wr_payload,
    input  wire logic     stage_busy,
    output logic          in_rdy,
    // Read side
    output logic          out_valid,
    output payload_t      out_payload,
    input  wire logic     out_rdy,
    output logic          oflow
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               run;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    function automatic logic [PTR_WID-1:0] ptr_next(input logic [PTR_WID-1:0] p);
        return (p == PTR_WID'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_WID'(DEPTH));
    assign wr_en = wr_valid && !full;
    assign rd_en = out_valid && out_rdy;

    assign out_valid   = (count != '0);
    assign out_payload = mem[rd_ptr];

    // Leave room for the beat already in the adapter register
    assign in_rdy = run && ((int'(count) + int'(stage_busy)) < DEPTH);

    always_ff @(posedge __packet_if or negedge rst_n) begin
        if (!rst_n) begin
            run    <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            oflow  <= 1'b0;
        end else begin
            run <= 1'b1;
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
            if (wr_valid && full) begin
                oflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge __packet_if) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_payload;
        end
    end

    a_no_write_full: assert property (
        @(posedge __packet_if) disable iff (!rst_n)
        wr_valid |-> !full
    ) else $error("write into a full skid buffer");

    // Stalled output holds until taken
    a_hold_stalled: assert property (
        @(posedge __packet_if) disable iff (!rst_n)
        (out_valid && !out_rdy) |=> (out_valid && $stable(out_payload))
    ) else $error("output beat changed while stalled");

endmodule : packet_skid_buffer

`default_nettype wire

/* hdl/packet_length_counter.sv */
//********************************************************************
// Length and error are reported one cycle after the eop beat; counts
// above MAX_PKT_BYTES saturate and raise a warning
//********************************************************************
`timescale 1ns/100ps
`default_nettype none

module packet_length_counter
    import axis_pkg::*;
    import packet_pkg::*;
(
    input  wire logic __packet_if,
    input  wire logic rst_n,
    input  wire logic beat_valid,
    input  wire logic beat_rdy,
    input  wire logic beat_eop,
    input  wire mty_t beat_mty,
    input  wire logic beat_err,
    output logic      len_valid,
    output len_t      len,
    output logic      len_err
);

    localparam int SUM_WID = LEN_WID + 1;

    logic               beat_acc;
    logic [SUM_WID-1:0] sum;
    len_t               sum_sat;
    len_t               acc;
    logic               err_acc;

    assign beat_acc = beat_valid && beat_rdy;

    // Running total including the current beat
    assign sum     = SUM_WID'(acc) + SUM_WID'(DATA_BYTE_WID) - SUM_WID'(beat_mty);
    assign sum_sat = (sum > SUM_WID'(MAX_PKT_BYTES)) ? len_t'(MAX_PKT_BYTES) : len_t'(sum);

    always_ff @(posedge __packet_if or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            err_acc   <= 1'b0;
            len_valid <= 1'b0;
        end else begin
            len_valid <= beat_acc && beat_eop;
            if (beat_acc) begin
                acc     <= beat_eop ? '0 : sum_sat;
                err_acc <= beat_eop ? 1'b0 : (err_acc | beat_err);
            end
        end
    end

    always_ff @(posedge __packet_if) begin
        if (beat_acc && beat_eop) begin
            len     <= sum_sat;
            len_err <= err_acc | beat_err;
        end
    end

    a_len_range: assert property (
        @(posedge __packet_if) disable iff (!rst_n)
        beat_acc |-> (sum <= SUM_WID'(MAX_PKT_BYTES))
    ) else $warning("packet longer than %0d bytes, length saturated", MAX_PKT_BYTES);

endmodule : packet_length_counter

`default_nettype wire

/* hdl/axis_packet_ingress.sv */
//********************************************************************
// AXI-S to packet ingress; unloaded latency is two cycles from the
// tready transfer, and oflow should never rise
//********************************************************************
`timescale 1ns/100ps
`default_nettype none

module axis_packet_ingress
    import axis_pkg::*;
    import packet_pkg::*;
(
    input  wire logic   __packet_if,
    input  wire logic   rst_n,
    // AXI-S slave
    input  wire logic   tvalid,
    output logic        tready,
    input  wire tdata_t tdata,
    input  wire tkeep_t tkeep,
    input  wire logic   tlast,
    input  wire logic   err,
    input  wire meta_t  meta,
    // Packet master
    output logic        packet_valid,
    input  wire logic   packet_rdy,
    output data_t       packet_data,
    output logic        packet_eop,
    output mty_t        packet_mty,
    output logic        packet_err,
    output meta_t       packet_meta,
    // Length report
    output logic        len_valid,
    output len_t        len,
    output logic        len_err,
    output logic        oflow
);

    logic      stage_valid;
    data_t     stage_data;
    logic      stage_eop;
    mty_t      stage_mty;
    logic      stage_err;
    meta_t     stage_meta;
    pkt_beat_t stage_beat;
    pkt_beat_t out_beat;

    axi4s_to_packet_adapter #(
        .meta_t (meta_t)
    ) i_axi4s_to_packet_adapter (
        .__packet_if (__packet_if),
        .rst_n       (rst_n),
        .tvalid      (tvalid),
        .tready      (tready),
        .tdata       (tdata),
        .tkeep       (tkeep),
        .tlast       (tlast),
        .err         (err),
        .meta        (meta),
        .stage_valid (stage_valid),
        .stage_data  (stage_data),
        .stage_eop   (stage_eop),
        .stage_mty   (stage_mty),
        .stage_err   (stage_err),
        .stage_meta  (stage_meta)
    );

    assign stage_beat = '{
        data: stage_data,
        eop:  stage_eop,
        mty:  stage_mty,
        err:  stage_err,
        meta: stage_meta
    };

    // The adapter register is the only in-flight beat
    packet_skid_buffer #(
        .payload_t (pkt_beat_t)
    ) i_packet_skid_buffer (
        .__packet_if (__packet_if),
        .rst_n       (rst_n),
        .wr_valid    (stage_valid),
        .wr_payload  (stage_beat),
        .stage_busy  (stage_valid),
        .in_rdy      (tready),
        .out_valid   (packet_valid),
        .out_payload (out_beat),
        .out_rdy     (packet_rdy),
        .oflow       (oflow)
    );

    assign packet_data = out_beat.data;
    assign packet_eop  = out_beat.eop;
    assign packet_mty  = out_beat.mty;
    assign packet_err  = out_beat.err;
    assign packet_meta = out_beat.meta;

    packet_length_counter i_packet_length_counter (
        .__packet_if (__packet_if),
        .rst_n       (rst_n),
        .beat_valid  (packet_valid),
        .beat_rdy    (packet_rdy),
        .beat_eop    (packet_eop),
        .beat_mty    (packet_mty),
        .beat_err    (packet_err),
        .len_valid   (len_valid),
        .len         (len),
        .len_err     (len_err)
    );

    // Ready look-ahead in the buffer must cover the adapter stage
    a_no_oflow: assert property (
        @(posedge __packet_if) disable iff (!rst_n)
        !oflow
    ) else $error("skid buffer of %0d entries overflowed", SKID_DEPTH);

endmodule : axis_packet_ingress

`default_nettype wire

/* dv/tb_axis_packet_ingress.sv */
//**********************************************************************
// Reads dv/axis_packet_golden.txt relative to the run directory; sink
// back-pressure is random, source tvalid stays high while beats remain
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_axis_packet_ingress
    import axis_pkg::*;
    import packet_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int REC_WORDS    = 6;
    localparam int MAX_RECS     = 64;

    // Record kinds in the first column of the golden file
    localparam int KIND_IN  = 1;
    localparam int KIND_OUT = 2;
    localparam int KIND_LEN = 3;

    logic   __packet_if;
    logic   rst_n;
    logic   tvalid;
    logic   tready;
    tdata_t tdata;
    tkeep_t tkeep;
    logic   tlast;
    logic   err;
    meta_t  meta;
    logic   packet_valid;
    logic   packet_rdy;
    data_t  packet_data;
    logic   packet_eop;
    mty_t   packet_mty;
    logic   packet_err;
    meta_t  packet_meta;
    logic   len_valid;
    len_t   len;
    logic   len_err;
    logic   oflow;

    logic [63:0] golden [MAX_RECS*REC_WORDS];
    int          s_idx[$];
    int          p_idx[$];
    int          l_idx[$];
    int          p_pos;
    int          l_pos;
    int          rec_count;
    logic        checking;
    logic        len_due;
    logic [15:0] lfsr_state;

    axis_packet_ingress UUT (.*);

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic load_golden();
        int kind;
        foreach (golden[i]) begin
            golden[i] = '0;
        end
        $readmemh("dv/axis_packet_golden.txt", golden);
        for (int r = 0; r < MAX_RECS; r++) begin
            kind = int'(golden[r*REC_WORDS]);
            case (kind)
                KIND_IN:  s_idx.push_back(r);
                KIND_OUT: p_idx.push_back(r);
                KIND_LEN: l_idx.push_back(r);
                default:  ;
            endcase
        end
        rec_count = s_idx.size() + p_idx.size() + l_idx.size();
        if (rec_count == 0) begin
            stop_on_error("The golden file holds no records");
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic expected);
        if (act !== expected) begin
            stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b",
                $time, name, act, expected));
        end
    endtask

    task automatic check_idle(input logic exp_tready);
        check_flag("tready", tready, exp_tready);
        check_flag("packet_valid", packet_valid, 1'b0);
        check_flag("len_valid", len_valid, 1'b0);
        check_flag("oflow", oflow, 1'b0);
    endtask

    task automatic check_beat(
        input int    rec,
        input data_t act_data,
        input logic  act_eop,
        input mty_t  act_mty,
        input logic  act_err,
        input meta_t act_meta
    );
        data_t exp_data;
        logic  exp_eop;
        mty_t  exp_mty;
        logic  exp_err;
        meta_t exp_meta;
        exp_data = data_t'(golden[rec*REC_WORDS+1]);
        exp_mty  = mty_t'(golden[rec*REC_WORDS+2]);
        exp_eop  = golden[rec*REC_WORDS+3][0];
        exp_err  = golden[rec*REC_WORDS+4][0];
        exp_meta = meta_t'(golden[rec*REC_WORDS+5]);
        if ({act_data, act_eop, act_mty, act_err, act_meta} !==
            {exp_data, exp_eop, exp_mty, exp_err, exp_meta}) begin
            stop_on_error($sformatf(
                "Fail at %0t: record %0d beat %h %b %0d %b %h, expected %h %b %0d %b %h",
                $time, rec, act_data, act_eop, act_mty, act_err, act_meta,
                exp_data, exp_eop, exp_mty, exp_err, exp_meta));
        end
    endtask

    task automatic check_length(input int rec, input len_t act_len, input logic act_err);
        len_t exp_len;
        logic exp_err;
        exp_len = len_t'(golden[rec*REC_WORDS+1]);
        exp_err = golden[rec*REC_WORDS+4][0];
        if ({act_len, act_err} !== {exp_len, exp_err}) begin
            stop_on_error($sformatf("Fail at %0t: record %0d length %0d err %b, expected %0d %b",
                $time, rec, act_len, act_err, exp_len, exp_err));
        end
    endtask

    initial begin
        __packet_if = 1'b0;
        forever #(CLK_PERIOD/2) __packet_if = ~__packet_if;
    end

    // Sink ready takes one LFSR bit per cycle
    initial begin
        lfsr_state = 16'd36;
        packet_rdy <= 1'b0;
        forever begin
            @(posedge __packet_if);
            if (checking) begin
                packet_rdy <= lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end
        end
    end

    initial begin
        int   s_pos;
        logic taken;
        rst_n  <= 1'b0;
        tvalid <= 1'b0;
        tdata  <= '0;
        tkeep  <= '0;
        tlast  <= 1'b0;
        err    <= 1'b0;
        meta   <= '0;
        checking = 1'b0;
        len_due  = 1'b0;
        p_pos = 0;
        l_pos = 0;
        load_golden();
        repeat (RESET_CYCLES) begin
            @(negedge __packet_if);
            check_idle(1'b0);
        end
        @(posedge __packet_if);
        rst_n <= 1'b1;
        @(posedge __packet_if);
        @(negedge __packet_if);
        check_idle(1'b1);
        checking = 1'b1;
        s_pos = 0;
        @(posedge __packet_if);
        while (s_pos < s_idx.size()) begin
            tvalid <= 1'b1;
            tdata  <= tdata_t'(golden[s_idx[s_pos]*REC_WORDS+1]);
            tkeep  <= tkeep_t'(golden[s_idx[s_pos]*REC_WORDS+2]);
            tlast  <= golden[s_idx[s_pos]*REC_WORDS+3][0];
            err    <= golden[s_idx[s_pos]*REC_WORDS+4][0];
            meta   <= meta_t'(golden[s_idx[s_pos]*REC_WORDS+5]);
            @(negedge __packet_if);
            taken = tready;
            @(posedge __packet_if);
            if (taken) begin
                s_pos++;
            end
        end
        tvalid <= 1'b0;
        while (p_pos < p_idx.size() || l_pos < l_idx.size()) begin
            @(posedge __packet_if);
        end
        // A few idle cycles to catch stray beats
        repeat (3) @(posedge __packet_if);
        $display("PASS: all tests");
        $finish;
    end

    // Transfers are judged at the falling edge, before the edge that takes them
    always @(negedge __packet_if) begin
        if (checking) begin
            check_flag("oflow", oflow, 1'b0);
            // Length report exactly one cycle after each eop transfer
            check_flag("len_valid", len_valid, len_due);
            if (len_valid) begin
                if (l_pos >= l_idx.size()) begin
                    stop_on_error("A length report appeared after all expected lengths");
                end else begin
                    check_length(l_idx[l_pos], len, len_err);
                    l_pos++;
                end
            end
            len_due = packet_valid && packet_rdy && packet_eop;
            if (packet_valid && packet_rdy) begin
                if (p_pos >= p_idx.size()) begin
                    stop_on_error("An output beat appeared after all expected beats");
                end else begin
                    check_beat(p_idx[p_pos], packet_data, packet_eop, packet_mty,
                        packet_err, packet_meta);
                    p_pos++;
                end
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = rec_count * 20 + 100;
        repeat (limit) @(posedge __packet_if);
        stop_on_error($sformatf("Timeout: run not finished after %0d clock periods", limit));
    end

endmodule : tb_axis_packet_ingress

`default_nettype wire

/* dv/axis_packet_golden.txt */
// kind data keep_or_mty last_or_eop err meta; kind 1 = input beat with tkeep,
// 2 = expected output beat with mty, 3 = expected length (len in data column)
1 0706050403020100 ff 0 0 11
1 0f0e0d0c0b0a0908 0f 1 0 11
2 0001020304050607 0 0 0 11
2 08090a0b0c0d0e0f 4 1 0 11
3 000000000000000c 0 0 0 00
1 8877665544332211 ff 1 1 22
2 1122334455667788 0 1 1 22
3 0000000000000008 0 0 1 00
1 deadbeefcafef00d ff 0 0 3c
1 0123456789abcdef ff 0 1 3c
1 00000000000000a5 01 1 0 3c
2 0df0fecaefbeadde 0 0 0 3c
2 efcdab8967452301 0 0 1 3c
2 a500000000000000 7 1 0 3c
3 0000000000000011 0 0 1 00
1 1020304050607080 ff 0 0 7f
1 0000000000ccbbaa 07 1 0 7f
2 8070605040302010 0 0 0 7f
2 aabbcc0000000000 5 1 0 7f
3 000000000000000b 0 0 0 00
1 00f1e2d3c4b5a697 7f 1 0 05
2 97a6b5c4d3e2f100 1 1 0 05
3 0000000000000007 0 0 0 00
1 a0a1a2a3a4a5a6a7 ff 0 0 9e
1 b0b1b2b3b4b5b6b7 ff 0 0 9e
1 c0c1c2c3c4c5c6c7 3f 1 1 9e
2 a7a6a5a4a3a2a1a0 0 0 0 9e
2 b7b6b5b4b3b2b1b0 0 0 0 9e
2 c7c6c5c4c3c2c1c0 2 1 1 9e
3 0000000000000016 0 0 1 00

/* verilog.f */
hdl/axis_pkg.sv
hdl/packet_pkg.sv
hdl/axi4s_to_packet_adapter.sv
hdl/packet_skid_buffer.sv
hdl/packet_length_counter.sv
hdl/axis_packet_ingress.sv
dv/tb_axis_packet_ingress.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root.
# The exit status is the simulation verdict.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_axis_packet_ingress \
    -f verilog.f -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation build or run failed" >&2; exit 1; }
